// ==== bench/ctrl_tb.sv ====
`timescale 1ns/1ps
`include "ctrl_defines.svh"

module ctrl_tb;
	import riscv_priv_pkg::*;
	import ctrl_pkg::*;

	localparam int unsigned TEST_CYCLES = 250;
	localparam int unsigned WATCHDOG_CYCLES = TEST_CYCLES + 150;

	localparam logic [5:0] C_FETCH = 6'h01; // Trap cause table
	localparam logic [5:0] C_ILLEGAL = 6'h02;
	localparam logic [5:0] C_BREAK = 6'h03;
	localparam logic [5:0] C_LOAD = 6'h05;
	localparam logic [5:0] C_STORE = 6'h07;
	localparam logic [5:0] C_ECALL_U = 6'h08;
	localparam logic [5:0] C_ECALL_M = 6'h0B;
	localparam logic [5:0] C_SOFT = 6'h23;
	localparam logic [5:0] C_TIMER = 6'h27;
	localparam logic [5:0] C_EXT = 6'h2B;
	localparam logic [5:0] C_FAST = 6'h30;
	localparam logic [5:0] C_NMI = 6'h3F;

	localparam int K_ILLEGAL = 0; // Exception kinds
	localparam int K_ILLEGAL_C = 1;
	localparam int K_ECALL = 2;
	localparam int K_EBRK = 3;
	localparam int K_FETCH = 4;
	localparam int K_LOAD = 5;
	localparam int K_STORE = 6;
	localparam int K_MRET = 7;
	localparam int K_WFI = 8;

	logic clk_i, rst_ni, fetch_enable_i, ctrl_busy_o, first_fetch_o;
	logic illegal_insn_i, ecall_insn_i, mret_insn_i, wfi_insn_i, ebrk_insn_i;
	logic csr_pipe_flush_i, instr_valid_i, instr_is_compressed_i, instr_fetch_err_i;
	logic [`CTRL_XLEN-1:0] instr_i, pc_id_i, lsu_addr_last_i, csr_mtval_o;
	logic [15:0] instr_compressed_i;
	logic instr_valid_clear_o, id_in_ready_o, instr_req_o, pc_set_o;
	pc_mux_e pc_mux_o;
	exc_pc_mux_e exc_pc_mux_o;
	exc_cause_t exc_cause_o;
	logic load_err_i, store_err_i, branch_set_i, jump_set_i;
	logic csr_mstatus_mie_i, csr_msip_i, csr_meip_i, irq_pending_i, irq_nm_i;
	logic [`CTRL_FAST_IRQS-1:0] csr_mfip_i;
	logic csr_save_if_o, csr_save_id_o, csr_restore_mret_id_o, csr_save_cause_o;
	priv_lvl_e priv_mode_i;
	logic csr_mstatus_tw_i, stall_i;

	logic boot_idle_chk, boot_chk, ff_chk, trap_chk, eret_chk; // Check windows
	logic irq_chk, irq_block_chk, sleep_chk, jump_chk;
	logic [5:0] exp_cause;
	logic [31:0] exp_mtval;
	logic [31:0] lfsr;
	int unsigned error_count;

	ctrl_top UUT (.*);

	initial begin
		clk_i = 1'b0;
		forever #50 clk_i = ~clk_i;
	end

	// ########################################
	// Reporting and helpers
	// ########################################

	task automatic report_mismatch(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		error_count++;
		$display("MISMATCH %s expected 0x%0h actual 0x%0h at %0t", name, expected, actual, $time);
		$display("Test failed");
		$fatal(1, "Stopped at first error");
	endtask

	function automatic logic [31:0] lfsr_next(input logic [31:0] state);
		return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]}; // x^32+x^22+x^2+x+1
	endfunction

	task automatic draw_bits(input int unsigned nbits, output logic [31:0] value);
		value = '0;
		for (int unsigned i = 0; i < nbits; i++) begin
			lfsr = lfsr_next(lfsr);
			value = {value[30:0], lfsr[0]};
		end
	endtask

	// Lowest priority first so each higher source overrides
	function automatic logic [5:0] expected_irq_cause(input logic nm,
			input logic [`CTRL_FAST_IRQS-1:0] mfip, input logic meip, input logic msip);
		logic [5:0] cause;
		cause = C_TIMER;
		if (msip) cause = C_SOFT;
		if (meip) cause = C_EXT;
		for (int i = 0; i < `CTRL_FAST_IRQS; i++) begin
			if (mfip[i]) cause = C_FAST + 6'(i);
		end
		if (nm) cause = C_NMI;
		return cause;
	endfunction

	task automatic clear_decode_flags();
		illegal_insn_i = 1'b0;
		ecall_insn_i = 1'b0;
		mret_insn_i = 1'b0;
		wfi_insn_i = 1'b0;
		ebrk_insn_i = 1'b0;
		csr_pipe_flush_i = 1'b0;
		instr_fetch_err_i = 1'b0;
		load_err_i = 1'b0;
		store_err_i = 1'b0;
		instr_is_compressed_i = 1'b0;
		priv_mode_i = PRIV_LVL_M;
		csr_mstatus_tw_i = 1'b0;
	endtask

	task automatic clear_irq_inputs();
		irq_nm_i = 1'b0;
		irq_pending_i = 1'b0;
		csr_mstatus_mie_i = 1'b0;
		csr_msip_i = 1'b0;
		csr_meip_i = 1'b0;
		csr_mfip_i = '0;
	endtask

	// Flag is held through the FLUSH cycle
	task automatic apply_exception(input int kind, input priv_lvl_e priv);
		logic [31:0] word;
		draw_bits(32, word);
		instr_i = word;
		draw_bits(16, word);
		instr_compressed_i = word[15:0];
		draw_bits(32, word);
		pc_id_i = word;
		draw_bits(32, word);
		lsu_addr_last_i = word;
		priv_mode_i = priv;
		instr_is_compressed_i = (kind == K_ILLEGAL_C);
		exp_mtval = '0;
		trap_chk = 1'b1;
		case (kind)
			K_ILLEGAL: begin
				illegal_insn_i = 1'b1;
				exp_cause = C_ILLEGAL;
				exp_mtval = instr_i;
			end
			K_ILLEGAL_C: begin
				illegal_insn_i = 1'b1;
				exp_cause = C_ILLEGAL;
				exp_mtval = {16'h0000, instr_compressed_i}; // Zero-extended half word
			end
			K_ECALL: begin
				ecall_insn_i = 1'b1;
				exp_cause = (priv == PRIV_LVL_M) ? C_ECALL_M : C_ECALL_U;
			end
			K_EBRK: begin
				ebrk_insn_i = 1'b1;
				exp_cause = C_BREAK;
			end
			K_FETCH: begin
				instr_fetch_err_i = 1'b1;
				exp_cause = C_FETCH;
				exp_mtval = pc_id_i;
			end
			K_LOAD: begin
				load_err_i = 1'b1;
				exp_cause = C_LOAD;
				exp_mtval = lsu_addr_last_i;
			end
			K_STORE: begin
				store_err_i = 1'b1;
				exp_cause = C_STORE;
				exp_mtval = lsu_addr_last_i;
			end
			K_MRET: begin
				mret_insn_i = 1'b1;
				exp_cause = C_ILLEGAL;
				exp_mtval = instr_i;
				if (priv == PRIV_LVL_M) begin
					trap_chk = 1'b0; // Legal return
					eret_chk = 1'b1;
				end
			end
			K_WFI: begin
				wfi_insn_i = 1'b1;
				csr_mstatus_tw_i = 1'b1;
				exp_cause = C_ILLEGAL;
				exp_mtval = instr_i;
			end
			default: trap_chk = 1'b0;
		endcase
		@(negedge clk_i);
		trap_chk = 1'b0;
		eret_chk = 1'b0;
		@(negedge clk_i);
		clear_decode_flags();
	endtask

	// NMI cases run with MIE cleared and all others with a pending enabled source
	task automatic take_irq(input logic nm, input logic [`CTRL_FAST_IRQS-1:0] mfip,
			input logic meip, input logic msip);
		irq_nm_i = nm;
		irq_pending_i = ~nm;
		csr_mstatus_mie_i = ~nm;
		csr_mfip_i = mfip;
		csr_meip_i = meip;
		csr_msip_i = msip;
		exp_cause = expected_irq_cause(nm, mfip, meip, msip);
		irq_chk = 1'b1;
		@(negedge clk_i);
		irq_chk = 1'b0;
		@(negedge clk_i);
		clear_irq_inputs();
	endtask

	task automatic hold_blocked_irq(input logic nm, input logic pending, input logic mie);
		irq_nm_i = nm;
		irq_pending_i = pending;
		csr_meip_i = pending;
		csr_mstatus_mie_i = mie;
		irq_block_chk = 1'b1;
		repeat (3) @(negedge clk_i);
		irq_block_chk = 1'b0;
		clear_irq_inputs();
		@(negedge clk_i);
	endtask

	// ########################################
	// Checks
	// ########################################

	a_idle_req: assert property (@(posedge clk_i) boot_idle_chk |-> !instr_req_o)
		else report_mismatch("instr_req_o", 32'h0, $sampled(instr_req_o));
	a_idle_pc_set: assert property (@(posedge clk_i) boot_idle_chk |-> pc_set_o)
		else report_mismatch("pc_set_o", 32'h1, $sampled(pc_set_o));
	a_idle_mux: assert property (@(posedge clk_i) boot_idle_chk |-> pc_mux_o == PC_BOOT)
		else report_mismatch("pc_mux_o", PC_BOOT, $sampled(pc_mux_o));
	a_boot_req: assert property (@(posedge clk_i) boot_chk |=> instr_req_o)
		else report_mismatch("instr_req_o", 32'h1, $sampled(instr_req_o));
	a_boot_pc_set: assert property (@(posedge clk_i) boot_chk |=> pc_set_o)
		else report_mismatch("pc_set_o", 32'h1, $sampled(pc_set_o));
	a_boot_mux: assert property (@(posedge clk_i) boot_chk |=> pc_mux_o == PC_BOOT)
		else report_mismatch("pc_mux_o", PC_BOOT, $sampled(pc_mux_o));
	a_first_fetch: assert property (@(posedge clk_i) ff_chk |=> first_fetch_o)
		else report_mismatch("first_fetch_o", 32'h1, $sampled(first_fetch_o));
	a_trap_pc_set: assert property (@(posedge clk_i) trap_chk |=> pc_set_o)
		else report_mismatch("pc_set_o", 32'h1, $sampled(pc_set_o));
	a_trap_mux: assert property (@(posedge clk_i) trap_chk |=> pc_mux_o == PC_EXC)
		else report_mismatch("pc_mux_o", PC_EXC, $sampled(pc_mux_o));
	a_trap_save: assert property (@(posedge clk_i) trap_chk |=> csr_save_id_o)
		else report_mismatch("csr_save_id_o", 32'h1, $sampled(csr_save_id_o));
	a_trap_cause: assert property (@(posedge clk_i) trap_chk |=> exc_cause_o == exp_cause)
		else report_mismatch("exc_cause_o", $sampled(exp_cause), $sampled(exc_cause_o));
	a_trap_mtval: assert property (@(posedge clk_i) trap_chk |=> csr_mtval_o == exp_mtval)
		else report_mismatch("csr_mtval_o", $sampled(exp_mtval), $sampled(csr_mtval_o));
	a_eret_mux: assert property (@(posedge clk_i) eret_chk |=> pc_mux_o == PC_ERET)
		else report_mismatch("pc_mux_o", PC_ERET, $sampled(pc_mux_o));
	a_eret_restore: assert property (@(posedge clk_i) eret_chk |=> csr_restore_mret_id_o)
		else report_mismatch("csr_restore_mret_id_o", 32'h1, $sampled(csr_restore_mret_id_o));
	a_irq_save: assert property (@(posedge clk_i) irq_chk |=> csr_save_if_o)
		else report_mismatch("csr_save_if_o", 32'h1, $sampled(csr_save_if_o));
	a_irq_vector: assert property (@(posedge clk_i) irq_chk |=> exc_pc_mux_o == EXC_PC_IRQ)
		else report_mismatch("exc_pc_mux_o", EXC_PC_IRQ, $sampled(exc_pc_mux_o));
	a_irq_cause_save: assert property (@(posedge clk_i) irq_chk |=> csr_save_cause_o)
		else report_mismatch("csr_save_cause_o", 32'h1, $sampled(csr_save_cause_o));
	a_irq_cause: assert property (@(posedge clk_i) irq_chk |=> exc_cause_o == exp_cause)
		else report_mismatch("exc_cause_o", $sampled(exp_cause), $sampled(exc_cause_o));
	a_irq_blocked: assert property (@(posedge clk_i) irq_block_chk |=> !csr_save_if_o)
		else report_mismatch("csr_save_if_o", 32'h0, $sampled(csr_save_if_o));
	a_sleep_busy: assert property (@(posedge clk_i) sleep_chk |-> !ctrl_busy_o)
		else report_mismatch("ctrl_busy_o", 32'h0, $sampled(ctrl_busy_o));
	a_sleep_req: assert property (@(posedge clk_i) sleep_chk |-> !instr_req_o)
		else report_mismatch("instr_req_o", 32'h0, $sampled(instr_req_o));
	a_jump_pc_set: assert property (@(posedge clk_i) jump_chk |-> pc_set_o)
		else report_mismatch("pc_set_o", 32'h1, $sampled(pc_set_o));
	a_jump_mux: assert property (@(posedge clk_i) jump_chk |-> pc_mux_o == PC_JUMP)
		else report_mismatch("pc_mux_o", PC_JUMP, $sampled(pc_mux_o));
	a_stall_ready: assert property (@(posedge clk_i) stall_i |-> !id_in_ready_o)
		else report_mismatch("id_in_ready_o", 32'h0, $sampled(id_in_ready_o));
	a_flush_ready: assert property (@(posedge clk_i) (trap_chk || eret_chk) |=> !id_in_ready_o)
		else report_mismatch("id_in_ready_o", 32'h0, $sampled(id_in_ready_o));
	a_flush_clear: assert property (@(posedge clk_i)
		(trap_chk || eret_chk) |=> instr_valid_clear_o)
		else report_mismatch("instr_valid_clear_o", 32'h1, $sampled(instr_valid_clear_o));

	// ########################################
	// Stimulus
	// ########################################

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk_i);
		$display("Timeout: the directed sequence did not end within %0d cycles", WATCHDOG_CYCLES);
		$display("Test failed");
		$fatal(1, "Watchdog expired");
	end

	initial begin
		logic [31:0] bits;
		logic [`CTRL_FAST_IRQS-1:0] mfip;
		lfsr = 32'h124a;
		error_count = 0;
		rst_ni = 1'b0;
		fetch_enable_i = 1'b0;
		instr_valid_i = 1'b0;
		instr_i = '0;
		instr_compressed_i = '0;
		pc_id_i = '0;
		lsu_addr_last_i = '0;
		branch_set_i = 1'b0;
		jump_set_i = 1'b0;
		stall_i = 1'b0;
		clear_decode_flags();
		clear_irq_inputs();
		{boot_idle_chk, boot_chk, ff_chk, trap_chk, eret_chk} = '0;
		{irq_chk, irq_block_chk, sleep_chk, jump_chk} = '0;
		exp_cause = '0;
		exp_mtval = '0;
		repeat (5) @(posedge clk_i);
		@(negedge clk_i);
		rst_ni = 1'b1;
		boot_idle_chk = 1'b1;
		repeat (2) @(negedge clk_i);
		fetch_enable_i = 1'b1;
		boot_idle_chk = 1'b0;
		boot_chk = 1'b1;
		@(negedge clk_i);
		boot_chk = 1'b0;
		ff_chk = 1'b1;
		@(negedge clk_i);
		ff_chk = 1'b0;
		instr_valid_i = 1'b1;
		@(negedge clk_i); // Now in DECODE

		apply_exception(K_ILLEGAL, PRIV_LVL_M);
		apply_exception(K_ILLEGAL_C, PRIV_LVL_M);
		apply_exception(K_ECALL, PRIV_LVL_M);
		apply_exception(K_ECALL, PRIV_LVL_U);
		apply_exception(K_EBRK, PRIV_LVL_M);
		apply_exception(K_FETCH, PRIV_LVL_M);
		apply_exception(K_LOAD, PRIV_LVL_M);
		apply_exception(K_STORE, PRIV_LVL_M);
		apply_exception(K_MRET, PRIV_LVL_U);
		apply_exception(K_WFI, PRIV_LVL_U);
		apply_exception(K_MRET, PRIV_LVL_M);

		take_irq(1'b0, '0, 1'b0, 1'b0);
		take_irq(1'b0, '0, 1'b0, 1'b1);
		take_irq(1'b0, '0, 1'b1, 1'b1);
		take_irq(1'b0, 15'h4008, 1'b1, 1'b1);
		for (int n = 0; n < 6; n++) begin
			draw_bits(`CTRL_FAST_IRQS, bits);
			mfip = bits[`CTRL_FAST_IRQS-1:0];
			draw_bits(2, bits);
			if (bits[1:0] != 2'b11) mfip = '0; // Fast lines in about a quarter of the draws
			draw_bits(2, bits);
			take_irq(1'b0, mfip, bits[1], bits[0]);
		end
		hold_blocked_irq(1'b0, 1'b1, 1'b0);
		take_irq(1'b1, '0, 1'b0, 1'b0);
		hold_blocked_irq(1'b1, 1'b0, 1'b0); // NMI already in service
		apply_exception(K_MRET, PRIV_LVL_M);
		take_irq(1'b1, '0, 1'b0, 1'b0);

		branch_set_i = 1'b1;
		jump_chk = 1'b1;
		@(negedge clk_i);
		branch_set_i = 1'b0;
		jump_set_i = 1'b1;
		@(negedge clk_i);
		jump_set_i = 1'b0;
		jump_chk = 1'b0;

		stall_i = 1'b1;
		irq_pending_i = 1'b1;
		csr_mstatus_mie_i = 1'b1;
		csr_meip_i = 1'b1;
		irq_block_chk = 1'b1;
		repeat (3) @(negedge clk_i);
		stall_i = 1'b0;
		irq_block_chk = 1'b0;
		exp_cause = C_EXT;
		irq_chk = 1'b1; // Deferred interrupt must still be taken
		@(negedge clk_i);
		irq_chk = 1'b0;
		@(negedge clk_i);
		clear_irq_inputs();

		wfi_insn_i = 1'b1;
		repeat (2) @(negedge clk_i);
		clear_decode_flags();
		instr_valid_i = 1'b0;
		sleep_chk = 1'b1;
		repeat (4) @(negedge clk_i);
		irq_pending_i = 1'b1; // Wake with MIE cleared
		ff_chk = 1'b1;
		@(negedge clk_i);
		sleep_chk = 1'b0;
		ff_chk = 1'b0;
		irq_pending_i = 1'b0;
		instr_valid_i = 1'b1;
		repeat (3) @(negedge clk_i);

		if (error_count == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

// ==== common/ctrl_defines.svh ====
`ifndef CTRL_DEFINES_SVH
`define CTRL_DEFINES_SVH

// ########################################
// Controller dimensions
// ########################################

`define CTRL_XLEN 32 // Data and address width

`define CTRL_FAST_IRQS 15 // Fast interrupt lines

`define CTRL_CAUSE_W 6 // Top bit flags an interrupt

`endif

// ==== common/ctrl_exc_if.sv ====
`timescale 1ns/1ps

interface ctrl_exc_if;

	logic ecall; // Qualified decode flags
	logic ebrk;
	logic mret;
	logic wfi;
	logic csr_flush;
	logic fetch_err;

	logic special_req; // Decode must go through FLUSH
	logic exc_req_q;
	logic illegal_q;
	logic load_err_q;
	logic store_err_q;

	logic in_flush;

	modport detect (
		output ecall, ebrk, mret, wfi, csr_flush, fetch_err,
		output special_req, exc_req_q, illegal_q, load_err_q, store_err_q,
		input in_flush
	);

	modport fsm (
		input ecall, ebrk, mret, wfi, csr_flush, fetch_err,
		input special_req, exc_req_q, illegal_q, load_err_q, store_err_q,
		output in_flush
	);

endinterface

// ==== common/ctrl_irq_if.sv ====
`timescale 1ns/1ps

interface ctrl_irq_if;
	import riscv_priv_pkg::*;

	logic handle_irq;
	exc_cause_t irq_cause;
	logic nmi_mode; // NMI in service

	logic irq_taken; // Strobe from IRQ_TAKEN
	logic nmi_clear; // Strobe on mret

	modport arbiter (
		output handle_irq, irq_cause, nmi_mode,
		input irq_taken, nmi_clear
	);

	modport fsm (
		input handle_irq, irq_cause, nmi_mode,
		output irq_taken, nmi_clear
	);

endinterface

// ==== common/ctrl_pkg.sv ====
package ctrl_pkg;

	// ########################################
	// Controller FSM
	// ########################################

	typedef enum logic [2:0] {
		RESET,
		BOOT_SET,
		WAIT_SLEEP,
		SLEEP,
		FIRST_FETCH,
		DECODE,
		FLUSH,
		IRQ_TAKEN
	} ctrl_state_e;

	// ########################################
	// PC steering
	// ########################################

	typedef enum logic [1:0] {
		PC_BOOT = 2'd0,
		PC_JUMP = 2'd1,
		PC_EXC = 2'd2,
		PC_ERET = 2'd3
	} pc_mux_e;

	typedef enum logic {
		EXC_PC_EXC = 1'b0, // Synchronous trap vector
		EXC_PC_IRQ = 1'b1
	} exc_pc_mux_e;

endpackage

// ==== common/riscv_priv_pkg.sv ====
`include "ctrl_defines.svh"

package riscv_priv_pkg;

	// ########################################
	// Privilege levels
	// ########################################

	typedef enum logic [1:0] {
		PRIV_LVL_U = 2'b00,
		PRIV_LVL_M = 2'b11
	} priv_lvl_e;

	// ########################################
	// Trap causes
	// ########################################

	typedef logic [`CTRL_CAUSE_W-1:0] exc_cause_t;

	localparam exc_cause_t EXC_CAUSE_INSTR_ACCESS_FAULT = 6'h01;
	localparam exc_cause_t EXC_CAUSE_ILLEGAL_INSN = 6'h02;
	localparam exc_cause_t EXC_CAUSE_BREAKPOINT = 6'h03;
	localparam exc_cause_t EXC_CAUSE_LOAD_ACCESS_FAULT = 6'h05;
	localparam exc_cause_t EXC_CAUSE_STORE_ACCESS_FAULT = 6'h07;
	localparam exc_cause_t EXC_CAUSE_ECALL_UMODE = 6'h08;
	localparam exc_cause_t EXC_CAUSE_ECALL_MMODE = 6'h0B;

	localparam exc_cause_t EXC_CAUSE_IRQ_SOFTWARE_M = 6'h23;
	localparam exc_cause_t EXC_CAUSE_IRQ_TIMER_M = 6'h27;
	localparam exc_cause_t EXC_CAUSE_IRQ_EXTERNAL_M = 6'h2B;
	localparam exc_cause_t EXC_CAUSE_IRQ_FAST_BASE = 6'h30; // Plus line index
	localparam exc_cause_t EXC_CAUSE_IRQ_NM = 6'h3F;

endpackage

// ==== compile.f ====
+incdir+common
common/riscv_priv_pkg.sv
common/ctrl_pkg.sv
common/ctrl_exc_if.sv
common/ctrl_irq_if.sv
ctrl/ctrl_exc_detect.sv
ctrl/ctrl_irq_arbiter.sv
ctrl/ctrl_fsm.sv
hw/ctrl_top.sv
bench/ctrl_tb.sv

// ==== ctrl/ctrl_exc_detect.sv ====
`timescale 1ns/1ps

module ctrl_exc_detect (
	input logic clk_i,
	input logic rst_ni,
	input logic instr_valid_i,
	input logic illegal_insn_i,
	input logic ecall_insn_i,
	input logic mret_insn_i,
	input logic wfi_insn_i,
	input logic ebrk_insn_i,
	input logic csr_pipe_flush_i,
	input logic instr_fetch_err_i,
	input logic load_err_i,
	input logic store_err_i,
	input riscv_priv_pkg::priv_lvl_e priv_mode_i,
	input logic csr_mstatus_tw_i,
	ctrl_exc_if.detect exc
);
	import riscv_priv_pkg::*;

	logic illegal_umode;
	logic illegal_d;
	logic exc_req_d;
	logic lsu_req_d;

	assign exc.ecall = ecall_insn_i & instr_valid_i;
	assign exc.ebrk = ebrk_insn_i & instr_valid_i;
	assign exc.mret = mret_insn_i & instr_valid_i;
	assign exc.wfi = wfi_insn_i & instr_valid_i;
	assign exc.csr_flush = csr_pipe_flush_i & instr_valid_i;
	assign exc.fetch_err = instr_fetch_err_i & instr_valid_i;

	// mret, and wfi under TW, need M mode
	assign illegal_umode = (priv_mode_i != PRIV_LVL_M) &
		(exc.mret | (csr_mstatus_tw_i & exc.wfi));

	assign illegal_d = ((illegal_insn_i & instr_valid_i) | illegal_umode) & ~exc.in_flush;
	assign exc_req_d = (exc.ecall | exc.ebrk | exc.fetch_err | illegal_d) & ~exc.in_flush;
	assign lsu_req_d = (load_err_i | store_err_i) & ~exc.in_flush;

	assign exc.special_req = exc.mret | exc.wfi | exc.csr_flush | exc_req_d | lsu_req_d;

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			exc.exc_req_q <= 1'b0;
			exc.illegal_q <= 1'b0;
			exc.load_err_q <= 1'b0;
			exc.store_err_q <= 1'b0;
		end else begin
			exc.exc_req_q <= exc_req_d;
			exc.illegal_q <= illegal_d;
			exc.load_err_q <= load_err_i & ~exc.in_flush;
			exc.store_err_q <= store_err_i & ~exc.in_flush;
		end
	end

	illegal_in_exc_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
		exc.illegal_q |-> exc.exc_req_q);

endmodule

// ==== ctrl/ctrl_fsm.sv ====
`timescale 1ns/1ps
`include "ctrl_defines.svh"

module ctrl_fsm (
	input logic clk_i,
	input logic rst_ni,
	input logic fetch_enable_i,
	input logic instr_valid_i,
	input logic [`CTRL_XLEN-1:0] instr_i,
	input logic [15:0] instr_compressed_i,
	input logic instr_is_compressed_i,
	input logic [`CTRL_XLEN-1:0] pc_id_i,
	input logic [`CTRL_XLEN-1:0] lsu_addr_last_i,
	input logic branch_set_i,
	input logic jump_set_i,
	input logic stall_i,
	input logic irq_pending_i,
	input logic irq_nm_i,
	input riscv_priv_pkg::priv_lvl_e priv_mode_i,
	ctrl_exc_if.fsm exc,
	ctrl_irq_if.fsm irq,
	output logic ctrl_busy_o,
	output logic first_fetch_o,
	output logic instr_req_o,
	output logic pc_set_o,
	output ctrl_pkg::pc_mux_e pc_mux_o,
	output ctrl_pkg::exc_pc_mux_e exc_pc_mux_o,
	output riscv_priv_pkg::exc_cause_t exc_cause_o,
	output logic [`CTRL_XLEN-1:0] csr_mtval_o,
	output logic csr_save_if_o,
	output logic csr_save_id_o,
	output logic csr_restore_mret_id_o,
	output logic csr_save_cause_o,
	output logic id_in_ready_o,
	output logic instr_valid_clear_o
);
	import riscv_priv_pkg::*;
	import ctrl_pkg::*;

	ctrl_state_e state_q;
	ctrl_state_e state_d;
	logic halt_if;
	logic flush_id;
	logic irq_taken;
	logic nmi_clear;

	assign exc.in_flush = (state_q == FLUSH);
	assign irq.irq_taken = irq_taken;
	assign irq.nmi_clear = nmi_clear;

	// ########################################
	// Next state and steering
	// ########################################

	always_comb begin
		state_d = state_q;
		instr_req_o = 1'b1;
		ctrl_busy_o = 1'b1;
		first_fetch_o = 1'b0;
		pc_set_o = 1'b0;
		pc_mux_o = PC_BOOT;
		exc_pc_mux_o = EXC_PC_IRQ;
		exc_cause_o = '0;
		csr_mtval_o = '0;
		csr_save_if_o = 1'b0;
		csr_save_id_o = 1'b0;
		csr_restore_mret_id_o = 1'b0;
		csr_save_cause_o = 1'b0;
		halt_if = 1'b0;
		flush_id = 1'b0;
		irq_taken = 1'b0;
		nmi_clear = 1'b0;

		case (state_q)
			RESET: begin
				instr_req_o = 1'b0;
				pc_set_o = 1'b1; // Keep boot PC loaded
				if (fetch_enable_i) begin
					state_d = BOOT_SET;
				end
			end
			BOOT_SET: begin
				pc_set_o = 1'b1;
				state_d = FIRST_FETCH;
			end
			WAIT_SLEEP, SLEEP: begin
				ctrl_busy_o = 1'b0;
				instr_req_o = 1'b0;
				halt_if = 1'b1;
				flush_id = 1'b1;
				if (state_q == WAIT_SLEEP) begin
					state_d = SLEEP;
				end else if (irq_nm_i || irq_pending_i) begin
					state_d = FIRST_FETCH; // Wake on any pending source
				end
			end
			FIRST_FETCH: begin
				first_fetch_o = 1'b1;
				if (id_in_ready_o) begin
					state_d = DECODE;
				end
				if (irq.handle_irq && !stall_i) begin
					state_d = IRQ_TAKEN;
					halt_if = 1'b1;
					flush_id = 1'b1;
				end
			end
			DECODE: begin
				if (instr_valid_i) begin
					if (exc.special_req) begin
						state_d = FLUSH;
						halt_if = 1'b1;
					end else if (branch_set_i || jump_set_i) begin
						pc_set_o = 1'b1;
						pc_mux_o = PC_JUMP;
					end
					if (irq.handle_irq && stall_i) begin
						halt_if = 1'b1; // Interrupt waits for stall to drop
					end
				end
				if (!stall_i && !exc.special_req && irq.handle_irq) begin
					state_d = IRQ_TAKEN;
					halt_if = 1'b1;
					flush_id = 1'b1;
				end
			end
			IRQ_TAKEN: begin
				if (irq.handle_irq) begin
					irq_taken = 1'b1;
					pc_set_o = 1'b1;
					pc_mux_o = PC_EXC;
					exc_pc_mux_o = EXC_PC_IRQ;
					csr_save_if_o = 1'b1;
					csr_save_cause_o = 1'b1;
					exc_cause_o = irq.irq_cause;
				end
				state_d = DECODE;
			end
			FLUSH: begin
				halt_if = 1'b1;
				flush_id = 1'b1;
				state_d = DECODE;
				if (exc.exc_req_q || exc.store_err_q || exc.load_err_q) begin
					pc_set_o = 1'b1;
					pc_mux_o = PC_EXC;
					exc_pc_mux_o = EXC_PC_EXC;
					csr_save_id_o = 1'b1;
					csr_save_cause_o = 1'b1;
					if (exc.fetch_err) begin
						exc_cause_o = EXC_CAUSE_INSTR_ACCESS_FAULT;
						csr_mtval_o = pc_id_i;
					end else if (exc.illegal_q) begin
						exc_cause_o = EXC_CAUSE_ILLEGAL_INSN;
						csr_mtval_o = instr_is_compressed_i ?
							{{(`CTRL_XLEN-16){1'b0}}, instr_compressed_i} : instr_i;
					end else if (exc.ecall) begin
						exc_cause_o = (priv_mode_i == PRIV_LVL_M) ?
							EXC_CAUSE_ECALL_MMODE : EXC_CAUSE_ECALL_UMODE;
					end else if (exc.ebrk) begin
						exc_cause_o = EXC_CAUSE_BREAKPOINT;
					end else if (exc.store_err_q) begin
						exc_cause_o = EXC_CAUSE_STORE_ACCESS_FAULT;
						csr_mtval_o = lsu_addr_last_i;
					end else begin
						exc_cause_o = EXC_CAUSE_LOAD_ACCESS_FAULT;
						csr_mtval_o = lsu_addr_last_i;
					end
				end else if (exc.mret) begin
					pc_set_o = 1'b1;
					pc_mux_o = PC_ERET;
					csr_restore_mret_id_o = 1'b1;
					nmi_clear = irq.nmi_mode;
				end else if (exc.wfi) begin
					state_d = WAIT_SLEEP;
				end else if (exc.csr_flush && irq.handle_irq) begin
					state_d = IRQ_TAKEN;
				end
			end
		endcase
	end

	assign id_in_ready_o = ~stall_i & ~halt_if;
	assign instr_valid_clear_o = (~stall_i & ~halt_if) | flush_id;

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			state_q <= RESET;
		end else begin
			state_q <= state_d;
		end
	end

	// ########################################
	// Checks
	// ########################################

	no_trap_in_sleep: assert property (@(posedge clk_i) disable iff (!rst_ni)
		(state_q == SLEEP) |-> !(pc_set_o || csr_save_cause_o));

	legal_state: assert property (@(posedge clk_i) disable iff (!rst_ni)
		state_q inside {RESET, BOOT_SET, WAIT_SLEEP, SLEEP,
			FIRST_FETCH, DECODE, FLUSH, IRQ_TAKEN});

endmodule

// ==== ctrl/ctrl_irq_arbiter.sv ====
`timescale 1ns/1ps
`include "ctrl_defines.svh"

module ctrl_irq_arbiter (
	input logic clk_i,
	input logic rst_ni,
	input logic irq_pending_i,
	input logic irq_nm_i,
	input logic csr_mstatus_mie_i,
	input logic csr_msip_i,
	input logic csr_meip_i,
	input logic [`CTRL_FAST_IRQS-1:0] csr_mfip_i,
	ctrl_irq_if.arbiter irq
);
	import riscv_priv_pkg::*;

	localparam int unsigned FAST_ID_W = $clog2(`CTRL_FAST_IRQS);

	logic nmi_mode_q;
	logic nmi_sel;
	logic [FAST_ID_W-1:0] mfip_id;

	assign nmi_sel = irq_nm_i & ~nmi_mode_q; // No NMI nesting
	assign irq.handle_irq = nmi_sel | (irq_pending_i & csr_mstatus_mie_i);
	assign irq.nmi_mode = nmi_mode_q;

	// Highest set fast line wins
	always_comb begin
		mfip_id = '0;
		for (int unsigned i = 0; i < `CTRL_FAST_IRQS; i++) begin
			if (csr_mfip_i[i]) begin
				mfip_id = FAST_ID_W'(i);
			end
		end
	end

	always_comb begin
		if (nmi_sel) begin
			irq.irq_cause = EXC_CAUSE_IRQ_NM;
		end else if (|csr_mfip_i) begin
			irq.irq_cause = EXC_CAUSE_IRQ_FAST_BASE + exc_cause_t'(mfip_id);
		end else if (csr_meip_i) begin
			irq.irq_cause = EXC_CAUSE_IRQ_EXTERNAL_M;
		end else if (csr_msip_i) begin
			irq.irq_cause = EXC_CAUSE_IRQ_SOFTWARE_M;
		end else begin
			irq.irq_cause = EXC_CAUSE_IRQ_TIMER_M; // Only source left
		end
	end

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			nmi_mode_q <= 1'b0;
		end else if (irq.nmi_clear) begin
			nmi_mode_q <= 1'b0;
		end else if (irq.irq_taken && nmi_sel) begin
			nmi_mode_q <= 1'b1;
		end
	end

	nmi_mode_after_take: assert property (@(posedge clk_i) disable iff (!rst_ni)
		$rose(nmi_mode_q) |-> $past(irq.irq_taken));

endmodule

// ==== hw/ctrl_top.sv ====
`timescale 1ns/1ps
`include "ctrl_defines.svh"

module ctrl_top (
	input logic clk_i,
	input logic rst_ni,
	input logic fetch_enable_i,
	output logic ctrl_busy_o,
	output logic first_fetch_o,
	input logic illegal_insn_i,
	input logic ecall_insn_i,
	input logic mret_insn_i,
	input logic wfi_insn_i,
	input logic ebrk_insn_i,
	input logic csr_pipe_flush_i,
	input logic instr_valid_i,
	input logic [`CTRL_XLEN-1:0] instr_i,
	input logic [15:0] instr_compressed_i,
	input logic instr_is_compressed_i,
	input logic instr_fetch_err_i,
	input logic [`CTRL_XLEN-1:0] pc_id_i,
	output logic instr_valid_clear_o,
	output logic id_in_ready_o,
	output logic instr_req_o,
	output logic pc_set_o,
	output ctrl_pkg::pc_mux_e pc_mux_o,
	output ctrl_pkg::exc_pc_mux_e exc_pc_mux_o,
	output riscv_priv_pkg::exc_cause_t exc_cause_o,
	input logic [`CTRL_XLEN-1:0] lsu_addr_last_i,
	input logic load_err_i,
	input logic store_err_i,
	input logic branch_set_i,
	input logic jump_set_i,
	input logic csr_mstatus_mie_i,
	input logic csr_msip_i,
	input logic csr_meip_i,
	input logic [`CTRL_FAST_IRQS-1:0] csr_mfip_i,
	input logic irq_pending_i,
	input logic irq_nm_i,
	output logic csr_save_if_o,
	output logic csr_save_id_o,
	output logic csr_restore_mret_id_o,
	output logic csr_save_cause_o,
	output logic [`CTRL_XLEN-1:0] csr_mtval_o,
	input riscv_priv_pkg::priv_lvl_e priv_mode_i,
	input logic csr_mstatus_tw_i,
	input logic stall_i // Merged pipeline stall
);

	ctrl_exc_if exc_bus ();
	ctrl_irq_if irq_bus ();

	ctrl_exc_detect u_exc_detect (
		.clk_i (clk_i),
		.rst_ni (rst_ni),
		.instr_valid_i (instr_valid_i),
		.illegal_insn_i (illegal_insn_i),
		.ecall_insn_i (ecall_insn_i),
		.mret_insn_i (mret_insn_i),
		.wfi_insn_i (wfi_insn_i),
		.ebrk_insn_i (ebrk_insn_i),
		.csr_pipe_flush_i (csr_pipe_flush_i),
		.instr_fetch_err_i (instr_fetch_err_i),
		.load_err_i (load_err_i),
		.store_err_i (store_err_i),
		.priv_mode_i (priv_mode_i),
		.csr_mstatus_tw_i (csr_mstatus_tw_i),
		.exc (exc_bus.detect)
	);

	ctrl_irq_arbiter u_irq_arbiter (
		.clk_i (clk_i),
		.rst_ni (rst_ni),
		.irq_pending_i (irq_pending_i),
		.irq_nm_i (irq_nm_i),
		.csr_mstatus_mie_i (csr_mstatus_mie_i),
		.csr_msip_i (csr_msip_i),
		.csr_meip_i (csr_meip_i),
		.csr_mfip_i (csr_mfip_i),
		.irq (irq_bus.arbiter)
	);

	ctrl_fsm u_fsm (
		.clk_i (clk_i),
		.rst_ni (rst_ni),
		.fetch_enable_i (fetch_enable_i),
		.instr_valid_i (instr_valid_i),
		.instr_i (instr_i),
		.instr_compressed_i (instr_compressed_i),
		.instr_is_compressed_i (instr_is_compressed_i),
		.pc_id_i (pc_id_i),
		.lsu_addr_last_i (lsu_addr_last_i),
		.branch_set_i (branch_set_i),
		.jump_set_i (jump_set_i),
		.stall_i (stall_i),
		.irq_pending_i (irq_pending_i),
		.irq_nm_i (irq_nm_i),
		.priv_mode_i (priv_mode_i),
		.exc (exc_bus.fsm),
		.irq (irq_bus.fsm),
		.ctrl_busy_o (ctrl_busy_o),
		.first_fetch_o (first_fetch_o),
		.instr_req_o (instr_req_o),
		.pc_set_o (pc_set_o),
		.pc_mux_o (pc_mux_o),
		.exc_pc_mux_o (exc_pc_mux_o),
		.exc_cause_o (exc_cause_o),
		.csr_mtval_o (csr_mtval_o),
		.csr_save_if_o (csr_save_if_o),
		.csr_save_id_o (csr_save_id_o),
		.csr_restore_mret_id_o (csr_restore_mret_id_o),
		.csr_save_cause_o (csr_save_cause_o),
		.id_in_ready_o (id_in_ready_o),
		.instr_valid_clear_o (instr_valid_clear_o)
	);

endmodule
